// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // line and bus geometry
    localparam int LINE_BITS   = 256;
    localparam int BEAT_BITS   = 64;
    localparam int BEATS       = 4;
    localparam int OFFSET_BITS = 5;

    // caches sharing the burst bus
    localparam int NUM_CLIENTS = 4;

    // front port, cpu side of a cache
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } ufp_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        resp;
    } ufp_rsp_t;

    // line port, memory side of a cache
    typedef struct packed {
        logic [31:0]          addr;
        logic                 read;
        logic                 write;
        logic [LINE_BITS-1:0] wdata;
    } dfp_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] rdata;
        logic                 resp;
    } dfp_rsp_t;

    // burst memory bus
    typedef struct packed {
        logic [31:0]          addr;
        logic                 read;
        logic                 write;
        logic [BEAT_BITS-1:0] wdata;
    } bmem_req_t;

    typedef struct packed {
        logic                 ready;
        logic [31:0]          raddr;
        logic [BEAT_BITS-1:0] rdata;
        logic                 rvalid;
    } bmem_rsp_t;

endpackage

// ==== verilog/line_cache.sv ====
`timescale 1ns/1ns

module line_cache #(
    parameter int SETS = 8
) (
    input  logic              clk,
    input  logic              rst,

    input  mem_pkg::ufp_req_t ufp_req,
    output mem_pkg::ufp_rsp_t ufp_rsp,

    output mem_pkg::dfp_req_t dfp_req,
    input  mem_pkg::dfp_rsp_t dfp_rsp
);

    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS   = 32 - mem_pkg::OFFSET_BITS - INDEX_BITS;
    localparam int WORD_BITS  = mem_pkg::OFFSET_BITS - 2;

    typedef enum logic [2:0] {
        s_idle,
        s_compare,
        s_writeback,
        s_fill,
        s_respond
    } state_t;

    state_t state;
    state_t state_next;

    // per-set bookkeeping
    logic [SETS-1:0]               valid;
    logic [SETS-1:0]               dirty;
    logic [TAG_BITS-1:0]           tag_arr  [SETS];
    logic [mem_pkg::LINE_BITS-1:0] data_arr [SETS];

    // address fields of the held front request
    logic [TAG_BITS-1:0]           tag;
    logic [INDEX_BITS-1:0]         index;
    logic [WORD_BITS-1:0]          word;

    logic                          req_read;
    logic                          req_write;
    logic                          req_present;
    logic                          hit;
    logic                          victim_dirty;
    logic [mem_pkg::LINE_BITS-1:0] line_rd;
    logic [31:0]                   word_rd;
    logic [31:0]                   rdata_r;

    // byte-wise merge of a store into the old word
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  mask
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign tag   = ufp_req.addr[31 -: TAG_BITS];
    assign index = ufp_req.addr[mem_pkg::OFFSET_BITS +: INDEX_BITS];
    assign word  = ufp_req.addr[2 +: WORD_BITS];

    assign req_read    = |ufp_req.rmask;
    assign req_write   = |ufp_req.wmask;
    assign req_present = req_read || req_write;

    // lookup against the indexed set
    assign line_rd      = data_arr[index];
    assign word_rd      = line_rd[word*32 +: 32];
    assign hit          = valid[index] && (tag_arr[index] == tag);
    assign victim_dirty = valid[index] && dirty[index];

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (req_present) begin
                    state_next = s_compare;
                end
            end
            s_compare: begin
                if (hit) begin
                    state_next = s_respond;
                end else if (victim_dirty) begin
                    state_next = s_writeback;
                end else begin
                    state_next = s_fill;
                end
            end
            s_writeback: begin
                // victim is in memory, now fetch the new line
                if (dfp_rsp.resp) begin
                    state_next = s_fill;
                end
            end
            s_fill: begin
                // replay the request against the filled line
                if (dfp_rsp.resp) begin
                    state_next = s_compare;
                end
            end
            s_respond: begin
                state_next = s_idle;
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            valid <= '0;
            dirty <= '0;
        end else begin
            state <= state_next;
            if (state == s_compare && hit && req_write) begin
                dirty[index] <= 1'b1;
            end
            if (state == s_fill && dfp_rsp.resp) begin
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;
            end
        end
    end

    // tag and line storage, plus the registered read word
    always_ff @(posedge clk) begin
        if (state == s_fill && dfp_rsp.resp) begin
            data_arr[index] <= dfp_rsp.rdata;
            tag_arr[index]  <= tag;
        end
        if (state == s_compare && hit) begin
            rdata_r <= word_rd;
            if (req_write) begin
                data_arr[index][word*32 +: 32] <= merge_bytes(word_rd, ufp_req.wdata,
                                                              ufp_req.wmask);
            end
        end
    end

    assign ufp_rsp.rdata = rdata_r;
    assign ufp_rsp.resp  = (state == s_respond);

    always_comb begin
        dfp_req.read  = (state == s_fill);
        dfp_req.write = (state == s_writeback);
        dfp_req.wdata = line_rd;
        if (state == s_writeback) begin
            // victim address comes from the stored tag
            dfp_req.addr = {tag_arr[index], index, {mem_pkg::OFFSET_BITS{1'b0}}};
        end else begin
            dfp_req.addr = {tag, index, {mem_pkg::OFFSET_BITS{1'b0}}};
        end
    end

endmodule

// ==== verilog/burst_arbiter.sv ====
`timescale 1ns/1ns

module burst_arbiter (
    input  logic               clk,
    input  logic               rst,

    input  mem_pkg::dfp_req_t  dfp_req [mem_pkg::NUM_CLIENTS],
    output mem_pkg::dfp_rsp_t  dfp_rsp [mem_pkg::NUM_CLIENTS],

    output mem_pkg::bmem_req_t bmem_req,
    input  mem_pkg::bmem_rsp_t bmem_rsp
);

    localparam int CLIENT_BITS = $clog2(mem_pkg::NUM_CLIENTS);
    localparam int BEAT_CNT_BITS = $clog2(mem_pkg::BEATS);
    localparam int OFF = mem_pkg::OFFSET_BITS;

    typedef enum logic [2:0] {
        s_choose,
        s_issue,
        s_receive,
        s_send,
        s_done
    } state_t;

    state_t state;
    state_t state_next;

    logic [CLIENT_BITS-1:0]        rr_ptr;
    logic [CLIENT_BITS-1:0]        grant;
    logic [CLIENT_BITS-1:0]        pick;
    logic                          pick_valid;
    logic [BEAT_CNT_BITS-1:0]      beat;
    logic                          last_beat;
    logic                          beat_ok;
    logic [mem_pkg::LINE_BITS-1:0] line_r;
    mem_pkg::dfp_req_t             sel_req;

    assign sel_req   = dfp_req[grant];
    assign last_beat = (beat == BEAT_CNT_BITS'(mem_pkg::BEATS - 1));

    // a returned beat only counts if it belongs to the granted line
    assign beat_ok = bmem_rsp.rvalid &&
                     (bmem_rsp.raddr[31:OFF] == sel_req.addr[31:OFF]);

    // round robin scan, starting one past the last client served
    always_comb begin
        logic [CLIENT_BITS-1:0] cand;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int i = 0; i < mem_pkg::NUM_CLIENTS; i++) begin
            cand = rr_ptr + CLIENT_BITS'(i);
            if (!pick_valid && (dfp_req[cand].read || dfp_req[cand].write)) begin
                pick       = cand;
                pick_valid = 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_choose: begin
                if (pick_valid) begin
                    state_next = s_issue;
                end
            end
            s_issue: begin
                // first read pulse or first write beat leaves here
                if (bmem_rsp.ready) begin
                    state_next = sel_req.write ? s_send : s_receive;
                end
            end
            s_receive: begin
                if (beat_ok && last_beat) begin
                    state_next = s_done;
                end
            end
            s_send: begin
                if (last_beat) begin
                    state_next = s_done;
                end
            end
            s_done: begin
                state_next = s_choose;
            end
            default: begin
                state_next = s_choose;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= s_choose;
            rr_ptr <= '0;
            grant  <= '0;
            beat   <= '0;
        end else begin
            state <= state_next;
            case (state)
                s_choose: begin
                    grant <= pick;
                    beat  <= '0;
                end
                s_issue: begin
                    if (bmem_rsp.ready && sel_req.write) begin
                        beat <= beat + 1'b1;
                    end
                end
                s_receive: begin
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                    end
                end
                s_send: begin
                    beat <= beat + 1'b1;
                end
                s_done: begin
                    rr_ptr <= grant + 1'b1;
                end
                default: begin
                    beat <= '0;
                end
            endcase
        end
    end

    // read beats land in their slice, lowest first
    always_ff @(posedge clk) begin
        if (state == s_receive && beat_ok) begin
            line_r[beat*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS] <= bmem_rsp.rdata;
        end
    end

    always_comb begin
        bmem_req.addr  = sel_req.addr;
        bmem_req.read  = (state == s_issue) && sel_req.read && bmem_rsp.ready;
        bmem_req.write = ((state == s_issue) && sel_req.write && bmem_rsp.ready) ||
                         (state == s_send);
        bmem_req.wdata = sel_req.wdata[beat*mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS];
    end

    always_comb begin
        for (int c = 0; c < mem_pkg::NUM_CLIENTS; c++) begin
            dfp_rsp[c].rdata = line_r;
            dfp_rsp[c].resp  = (state == s_done) && (grant == CLIENT_BITS'(c));
        end
    end

endmodule

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem #(
    parameter int I_SETS = 16,
    parameter int D_SETS = 8
) (
    input  logic               clk,
    input  logic               rst,

    input  mem_pkg::ufp_req_t  ooo_imem_req,
    output mem_pkg::ufp_rsp_t  ooo_imem_rsp,
    input  mem_pkg::ufp_req_t  ooo_dmem_req,
    output mem_pkg::ufp_rsp_t  ooo_dmem_rsp,
    input  mem_pkg::ufp_req_t  ppl_imem_req,
    output mem_pkg::ufp_rsp_t  ppl_imem_rsp,
    input  mem_pkg::ufp_req_t  ppl_dmem_req,
    output mem_pkg::ufp_rsp_t  ppl_dmem_rsp,

    output mem_pkg::bmem_req_t bmem_req,
    input  mem_pkg::bmem_rsp_t bmem_rsp
);

    // line ports, indexed by client number
    mem_pkg::dfp_req_t dfp_req [mem_pkg::NUM_CLIENTS];
    mem_pkg::dfp_rsp_t dfp_rsp [mem_pkg::NUM_CLIENTS];

    line_cache #(.SETS(I_SETS)) u_ooo_icache (
        .clk     (clk),
        .rst     (rst),
        .ufp_req (ooo_imem_req),
        .ufp_rsp (ooo_imem_rsp),
        .dfp_req (dfp_req[0]),
        .dfp_rsp (dfp_rsp[0])
    );

    line_cache #(.SETS(D_SETS)) u_ooo_dcache (
        .clk     (clk),
        .rst     (rst),
        .ufp_req (ooo_dmem_req),
        .ufp_rsp (ooo_dmem_rsp),
        .dfp_req (dfp_req[1]),
        .dfp_rsp (dfp_rsp[1])
    );

    line_cache #(.SETS(I_SETS)) u_ppl_icache (
        .clk     (clk),
        .rst     (rst),
        .ufp_req (ppl_imem_req),
        .ufp_rsp (ppl_imem_rsp),
        .dfp_req (dfp_req[2]),
        .dfp_rsp (dfp_rsp[2])
    );

    line_cache #(.SETS(D_SETS)) u_ppl_dcache (
        .clk     (clk),
        .rst     (rst),
        .ufp_req (ppl_dmem_req),
        .ufp_rsp (ppl_dmem_rsp),
        .dfp_req (dfp_req[3]),
        .dfp_rsp (dfp_rsp[3])
    );

    burst_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .dfp_req  (dfp_req),
        .dfp_rsp  (dfp_rsp),
        .bmem_req (bmem_req),
        .bmem_rsp (bmem_rsp)
    );

endmodule

// ==== testbench/burst_memory_model.sv ====
`timescale 1ns/1ns

module burst_memory_model (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::bmem_req_t bmem_req,
    output mem_pkg::bmem_rsp_t bmem_rsp
);

    localparam logic [31:0] FILL_KEY = 32'h3C96_A55A;

    // backing store of written beats, keyed by beat address
    logic [63:0]        mem [logic [31:0]];
    logic [31:0]        rng_state = 32'd78614;
    logic               rd_busy   = 1'b0;
    logic [31:0]        rd_addr   = '0;
    logic [1:0]         rd_beat   = '0;
    logic [1:0]         wr_beat   = '0;
    mem_pkg::bmem_rsp_t rsp_q     = '0;

    assign bmem_rsp = rsp_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] beat_addr(input logic [31:0] line, input logic [1:0] idx);
        return {line[31:5], idx, 3'b000};
    endfunction

    // unwritten beats hold their own address, high word xor a key
    function automatic logic [63:0] read_beat(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a ^ FILL_KEY, a};
    endfunction

    // bus requests and consumed beats are taken at the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rd_beat <= '0;
            wr_beat <= '0;
        end else begin
            if (bmem_req.read) begin
                rd_busy <= 1'b1;
                rd_addr <= bmem_req.addr;
                rd_beat <= '0;
            end
            if (bmem_req.write) begin
                mem[beat_addr(bmem_req.addr, wr_beat)] = bmem_req.wdata;
                wr_beat <= wr_beat + 2'd1;
            end
            if (rsp_q.rvalid) begin
                rd_beat <= rd_beat + 2'd1;
                if (rd_beat == 2'd3) begin
                    rd_busy <= 1'b0;
                end
            end
        end
    end

    // ready and rvalid change on the falling edge, with random gaps
    always @(negedge clk) begin
        if (rst) begin
            rsp_q <= '0;
        end else begin
            rng_state = xorshift32(rng_state);
            rsp_q.ready  <= !rd_busy && (wr_beat == 2'd0) && (rng_state[1:0] != 2'd0);
            rsp_q.rvalid <= rd_busy && (rng_state[9:8] != 2'd0);
            rsp_q.raddr  <= rd_addr;
            rsp_q.rdata  <= read_beat(beat_addr(rd_addr, rd_beat));
        end
    end

endmodule

// ==== testbench/mem_subsystem_sva.sv ====
`timescale 1ns/1ns

module mem_subsystem_sva (
    input logic               clk,
    input logic               rst,
    input mem_pkg::bmem_req_t bmem_req,
    input mem_pkg::bmem_rsp_t bmem_rsp,
    input mem_pkg::ufp_req_t  ufp_req,
    input mem_pkg::ufp_rsp_t  ufp_rsp
);

    logic front_req;

    assign front_req = (|ufp_req.rmask) || (|ufp_req.wmask);

    read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_req.read |=> !bmem_req.read)
        else $error("bus read held longer than one cycle");

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_req.read |-> bmem_rsp.ready)
        else $error("bus read issued while ready was low");

    // a write burst is four beats at one address
    write_run_of_four: assert property (@(posedge clk) disable iff (rst)
        $rose(bmem_req.write) |-> bmem_rsp.ready
            ##1 (bmem_req.write && $stable(bmem_req.addr))
            ##1 (bmem_req.write && $stable(bmem_req.addr))
            ##1 (bmem_req.write && $stable(bmem_req.addr))
            ##1 !bmem_req.write)
        else $error("bus write burst is not four beats with a stable address");

    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(bmem_req.read && bmem_req.write))
        else $error("bus read and write high together");

    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        ufp_rsp.resp |-> front_req)
        else $error("front resp without a request present");

endmodule

bind burst_arbiter mem_subsystem_sva u_bus_sva (
    .clk      (clk),
    .rst      (rst),
    .bmem_req (bmem_req),
    .bmem_rsp (bmem_rsp),
    .ufp_req  ('0),
    .ufp_rsp  ('0)
);

bind line_cache mem_subsystem_sva u_front_sva (
    .clk      (clk),
    .rst      (rst),
    .bmem_req ('0),
    .bmem_rsp ('0),
    .ufp_req  (ufp_req),
    .ufp_rsp  (ufp_rsp)
);

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk;
    logic               rst;
    mem_pkg::ufp_req_t  req [mem_pkg::NUM_CLIENTS];
    mem_pkg::ufp_rsp_t  rsp [mem_pkg::NUM_CLIENTS];
    mem_pkg::bmem_req_t bmem_req;
    mem_pkg::bmem_rsp_t bmem_rsp;

    // every word written so far, by word address
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] read_log [$];
    logic [31:0] base [mem_pkg::NUM_CLIENTS] = '{32'h0000_1000, 32'h0001_0000,
                                                 32'h0000_2000, 32'h0002_0000};
    int          write_cycles = 0;
    int          lat;

    mem_subsystem #(.I_SETS(16), .D_SETS(8)) u_dut (
        .clk          (clk),
        .rst          (rst),
        .ooo_imem_req (req[0]),
        .ooo_imem_rsp (rsp[0]),
        .ooo_dmem_req (req[1]),
        .ooo_dmem_rsp (rsp[1]),
        .ppl_imem_req (req[2]),
        .ppl_imem_rsp (rsp[2]),
        .ppl_dmem_req (req[3]),
        .ppl_dmem_rsp (rsp[3]),
        .bmem_req     (bmem_req),
        .bmem_rsp     (bmem_rsp)
    );

    burst_memory_model u_mem (
        .clk      (clk),
        .rst      (rst),
        .bmem_req (bmem_req),
        .bmem_rsp (bmem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // bus activity as the DUT sees it at each rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (bmem_req.read) begin
                read_log.push_back(bmem_req.addr);
            end
            if (bmem_req.write) begin
                write_cycles <= write_cycles + 1;
            end
        end
    end

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] byte_mask(input logic [3:0] mask);
        logic [31:0] bits;
        for (int b = 0; b < 4; b++) begin
            bits[b*8 +: 8] = {8{mask[b]}};
        end
        return bits;
    endfunction

    // fill of the memory model: low word is the beat address, high word that xor a key
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        logic [31:0] beat_addr;
        beat_addr = {addr[31:3], 3'b000};
        return addr[2] ? (beat_addr ^ 32'h3C96_A55A) : beat_addr;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        return shadow.exists(word_addr) ? shadow[word_addr] : initial_word(addr);
    endfunction

    task automatic check_latency(input int cycles, input string name);
        assert (cycles == 2) else begin
            $display("ERR %s expected %0d actual %0d", name, 2, cycles);
            stop_with_failure();
        end
    endtask

    task automatic access_port(
        input  int          port,
        input  logic [31:0] addr,
        input  logic [3:0]  rmask,
        input  logic [3:0]  wmask,
        input  logic [31:0] wdata,
        input  string       name,
        output int          cycles
    );
        logic [31:0] exp_word;
        logic [31:0] got_word;
        logic [31:0] keep;
        @(negedge clk);
        req[port] = '{addr: addr, rmask: rmask, wmask: wmask, wdata: wdata};
        cycles = 0;
        while (!rsp[port].resp && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!rsp[port].resp) begin
            $display("timeout waiting for a response on port %0d in %s", port, name);
            stop_with_failure();
        end
        got_word = rsp[port].rdata;
        exp_word = expected_word(addr);
        // resp is taken at the next rising edge, the request stays until then
        @(negedge clk);
        req[port] = '0;
        if (|rmask) begin
            keep = byte_mask(rmask);
            assert ((got_word & keep) == (exp_word & keep)) else begin
                $display("ERR %s expected %h actual %h", name, exp_word & keep, got_word & keep);
                stop_with_failure();
            end
        end
        if (|wmask) begin
            keep = byte_mask(wmask);
            shadow[{addr[31:2], 2'b00}] = (exp_word & ~keep) | (wdata & keep);
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int p = 0; p < mem_pkg::NUM_CLIENTS; p++) begin
            req[p] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // nothing moves before the first request
        repeat (6) begin
            @(negedge clk);
            for (int p = 0; p < mem_pkg::NUM_CLIENTS; p++) begin
                assert (!rsp[p].resp) else begin
                    $display("front resp on port %0d before any request", p);
                    stop_with_failure();
                end
            end
        end
        assert (read_log.size() == 0 && write_cycles == 0) else begin
            $display("bus activity before any request");
            stop_with_failure();
        end

        // one miss per port at once, served in client order
        fork
            access_port(0, base[0] + 32'h4, 4'hf, 4'h0, 32'h0, "miss_order_p0", lat);
            access_port(1, base[1] + 32'h4, 4'hf, 4'h0, 32'h0, "miss_order_p1", lat);
            access_port(2, base[2] + 32'h4, 4'hf, 4'h0, 32'h0, "miss_order_p2", lat);
            access_port(3, base[3] + 32'h4, 4'hf, 4'h0, 32'h0, "miss_order_p3", lat);
        join
        assert (read_log.size() >= 4) else begin
            $display("fewer than four bus reads for four misses");
            stop_with_failure();
        end
        for (int k = 0; k < mem_pkg::NUM_CLIENTS; k++) begin
            assert (read_log[k] == base[k]) else begin
                $display("ERR miss_order expected %h actual %h", base[k], read_log[k]);
                stop_with_failure();
            end
        end

        // initial pattern on misses and on repeat hits
        for (int p = 0; p < mem_pkg::NUM_CLIENTS; p++) begin
            access_port(p, base[p] + 32'h18, 4'hf, 4'h0, 32'h0, "hit_same_line", lat);
            check_latency(lat, "hit_same_line");
            access_port(p, base[p] + 32'h64, 4'hf, 4'h0, 32'h0, "miss_new_line", lat);
            access_port(p, base[p] + 32'h64, 4'h3, 4'h0, 32'h0, "repeat_hit", lat);
            check_latency(lat, "repeat_hit");
        end

        // byte-masked writes on the data ports
        for (int p = 1; p < mem_pkg::NUM_CLIENTS; p += 2) begin
            access_port(p, base[p] + 32'h8, 4'h0, 4'b0001, 32'hA1B2_C3D4, "write_byte0", lat);
            access_port(p, base[p] + 32'h8, 4'h0, 4'b0110, 32'h1122_3344, "write_mid", lat);
            access_port(p, base[p] + 32'h8, 4'hf, 4'h0, 32'h0, "read_masked", lat);
            access_port(p, base[p] + 32'hA0, 4'h0, 4'b1000, 32'h5566_7788, "write_miss", lat);
            access_port(p, base[p] + 32'hA0, 4'hf, 4'h0, 32'h0, "read_write_miss", lat);
        end

        // dirty victim goes out and comes back, one word per beat
        for (int p = 1; p < mem_pkg::NUM_CLIENTS; p += 2) begin
            for (int w = 0; w < mem_pkg::BEATS; w++) begin
                access_port(p, base[p] + 32'h40 + 32'(w*8 + (w%2)*4), 4'h0, 4'hf,
                            32'hDEAD_0000 + 32'(p*256 + w), "evict_write", lat);
            end
            access_port(p, base[p] + 32'h140, 4'hf, 4'h0, 32'h0, "evict_conflict", lat);
            for (int w = 0; w < mem_pkg::BEATS; w++) begin
                access_port(p, base[p] + 32'h40 + 32'(w*8 + (w%2)*4), 4'hf, 4'h0,
                            32'h0, "evict_reread", lat);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/mem_pkg.sv
verilog/line_cache.sv
verilog/burst_arbiter.sv
verilog/mem_subsystem.sv
testbench/burst_memory_model.sv
testbench/mem_subsystem_sva.sv
testbench/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run; the exit status is the simulator's
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsystem -f vlog.f -o sim_mem_subsystem &&
./obj_dir/sim_mem_subsystem || exit 1
